// File: tb/cpuTests.txt
// @0: program word count, debug value count, store count
// @10: program, one instruction per line with its constant; @100: dout values; @140: store address, data
@0
00000050 0000000e 00000007
@10
00000001 00000200  // 00 movRC r0, 0x200
00000201 00000007  // 08 movRC r2, 7
00000301 00000005  // 10 movRC r3, 5
03020441           // 18 addRRR r4 = r2 + r3
00040542 00000010  // 1c subRRC r5 = r4 - 0x10
03020646           // 24 shlRRR r6 = r2 << r3
00030648 00000100  // 28 mulAddRRC r6 = r6 + r3 * 0x100
00000644           // 30 incR r6
03060747           // 34 shrRRR r7 = r6 >> r3
00000745           // 38 decR r7
00000450           // 3c dout r4
00000550           // 40 dout r5
00000650           // 44 dout r6
00000750           // 48 dout r7
00000801 00000300  // 4c movRC r8, 0x300
00040808           // 54 store [r8] = r4
00050007 00000304  // 58 store [0x304] = r5
00060809 00000008  // 60 store [r8 + 8] = r6
0703080a 00000004  // 68 store [r8 + 4 * r3] = r7
00000a03 00000304  // 70 load r10 = [0x304]
00080b04           // 78 load r11 = [r8]
00080c05 00000008  // 7c load r12 = [r8 + 8]
03080d06 00000004  // 84 load r13 = [r8 + 4 * r3]
00000a50           // 8c dout r10
00000b50           // 90 dout r11
00000c50           // 94 dout r12
00000d50           // 98 dout r13
00000210           // 9c push r2
00000310           // a0 push r3
00000e11           // a4 pop r14
00000e50           // a8 dout r14
00000f01 000000bc  // ac movRC r15, 0xbc
00000030 000000c4  // b4 jmp 0xc4
00000250           // bc dout r2
00000013           // c0 ret
00000f12           // c4 call r15
00000050           // c8 dout r0
00000221 00000007  // cc cmpRC r2, 7
00000032 000000e4  // d4 jne 0xe4
00000031 000000e8  // dc je 0xe8
00000450           // e4 dout r4, skipped
00000350           // e8 dout r3
00030220           // ec cmpRR r2, r3
00000033 00000100  // f0 jlt 0x100
00000034 00000104  // f8 jgt 0x104
00000450           // 100 dout r4, skipped
02031024           // 104 r16 = r3 < r2
10000035 00000118  // 108 jz r16, 0x118
10000036 0000011c  // 110 jnz r16, 0x11c
00000450           // 118 dout r4, skipped
03021122           // 11c r17 = r2 == r3
11000035 0000012c  // 120 jz r17, 0x12c
00000450           // 128 dout r4, skipped
03021223           // 12c r18 = r2 != r3
02031325           // 130 r19 = r3 > r2
00001250           // 134 dout r18
00001350           // 138 dout r19
00000051           // 13c stall
@100
0000000c fffffffc 000005e1 0000002e
fffffffc 0000000c 000005e1 0000002e
00000005 00000007 00000204 00000005
00000001 00000000
@140
00000300 0000000c
00000304 fffffffc
00000308 000005e1
00000314 0000002e
00000200 00000007
00000204 00000005
00000204 000000c4

// File: vlog.f
src/cpuPkg.sv
src/instrDecoder.sv
src/registerFile.sv
src/addressUnit.sv
src/execUnit.sv
src/sequencer.sv
src/cpuCore.sv
tb/ramModel.sv
tb/tbCpu.sv

// File: Bender.yml
package:
  name: cpuCore

sources:
  - src/cpuPkg.sv
  - src/instrDecoder.sv
  - src/registerFile.sv
  - src/addressUnit.sv
  - src/execUnit.sv
  - src/sequencer.sv
  - src/cpuCore.sv
  - target: test
    files:
      - tb/ramModel.sv
      - tb/tbCpu.sv

// File: tb/tbCpu.sv
`timescale 1ns/1ps
`default_nettype none

module tbCpu;

  // Section offsets inside cpuTests.txt
  localparam int progBase = 'h10;
  localparam int dbgBase = 'h100;
  localparam int storeBase = 'h140;
  localparam int cyclesPerWord = 20;  // Timeout budget per program word
  localparam int stallRepeats = 3;    // Fetches of the stall word before stopping

  logic        clk;
  logic        reset;
  logic [31:0] ramIn, ramAddress, ramOut, dbgValue;
  logic        readAck, writeAck, readReq, writeReq, dbgValid;
  logic        storeValid;          // Store completed in the RAM
  logic [31:0] storeAddress, storeWord;

  logic [31:0] tests [0:511];
  int progLen, dbgCount, storeCount, limit;
  int dbgSeen, storeSeen, stallFetches, cycles;
  int mismatches, failures;
  logic outstanding, firstReqSeen;
  logic [31:0] stallAddress;

  cpuCore #(.dataWidth(32), .numRegs(64)) dut0 (
    .clk, .reset, .ramIn, .readAck, .writeAck,
    .ramAddress, .ramOut, .readReq, .writeReq, .dbgValid, .dbgValue
  );

  ramModel #(.depth(256)) ram0 (
    .clk, .reset,
    .address(ramAddress), .writeData(ramOut), .readReq, .writeReq,
    .readData(ramIn), .readAck, .writeAck,
    .storeValid, .storeAddress, .storeWord
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // One request in flight; after the last event only the stall word is fetched
  task automatic trackRequests();
    if (readAck || writeAck) outstanding = 1'b0;
    if (readReq || writeReq) begin
      if (outstanding) begin
        $display("%0d ns: new request issued before the previous one was acknowledged", $time);
        failures++;
      end
      outstanding = 1'b1;
      if (!firstReqSeen) begin
        firstReqSeen = 1'b1;
        if (writeReq) begin
          $display("%0d ns: first request after reset is a write, not a fetch", $time);
          failures++;
        end
        if (ramAddress !== 32'h0) begin
          $display("MISMATCH at %0d ns: ramAddress expected %h got %h", $time, 32'h0, ramAddress);
          mismatches++;
        end
      end
      if (dbgSeen == dbgCount && storeSeen == storeCount) begin
        if (ramAddress !== stallAddress) begin
          $display("MISMATCH at %0d ns: ramAddress expected %h got %h",
                   $time, stallAddress, ramAddress);
          mismatches++;
        end
        stallFetches++;
      end
    end
  endtask

  // Debug words and stores, compared in file order
  task automatic compareEvents();
    logic [31:0] expAddress;
    logic [31:0] expData;
    if (dbgValid) begin
      if (dbgSeen >= dbgCount) begin
        $display("%0d ns: unexpected extra debug output %h", $time, dbgValue);
        failures++;
      end else if (dbgValue !== tests[dbgBase + dbgSeen]) begin
        $display("MISMATCH at %0d ns: dbgValue expected %h got %h",
                 $time, tests[dbgBase + dbgSeen], dbgValue);
        mismatches++;
      end
      dbgSeen++;
    end
    if (storeValid) begin
      if (storeSeen >= storeCount) begin
        $display("%0d ns: unexpected extra store of %h to %h", $time, storeWord, storeAddress);
        failures++;
      end else begin
        expAddress = tests[storeBase + 2 * storeSeen];
        expData = tests[storeBase + 2 * storeSeen + 1];
        if (storeAddress !== expAddress) begin
          $display("MISMATCH at %0d ns: ramAddress expected %h got %h",
                   $time, expAddress, storeAddress);
          mismatches++;
        end
        if (storeWord !== expData) begin
          $display("MISMATCH at %0d ns: ramOut expected %h got %h", $time, expData, storeWord);
          mismatches++;
        end
      end
      storeSeen++;
    end
  endtask

  initial begin
    reset = 1'b1;
    mismatches = 0;
    failures = 0;
    dbgSeen = 0;
    storeSeen = 0;
    stallFetches = 0;
    cycles = 0;
    outstanding = 1'b0;
    firstReqSeen = 1'b0;
    $readmemh("tb/cpuTests.txt", tests);
    progLen = tests[0];
    dbgCount = tests[1];
    storeCount = tests[2];
    stallAddress = (progLen - 1) * 4;  // Last word is the stall
    limit = progLen * cyclesPerWord;
    repeat (16) @(posedge clk);
    // Program goes in while the core is still held in reset
    for (int i = 0; i < progLen; i++) begin
      ram0.loadWord(i, tests[progBase + i]);
    end
    @(negedge clk);
    reset = 1'b0;
    if (readReq !== 1'b0) begin
      $display("MISMATCH at %0d ns: readReq expected 0 got %b", $time, readReq);
      mismatches++;
    end
    if (writeReq !== 1'b0) begin
      $display("MISMATCH at %0d ns: writeReq expected 0 got %b", $time, writeReq);
      mismatches++;
    end
    if (dbgValid !== 1'b0) begin
      $display("MISMATCH at %0d ns: dbgValid expected 0 got %b", $time, dbgValid);
      mismatches++;
    end
    while (stallFetches < stallRepeats && cycles < limit) begin
      @(posedge clk);
      #1;  // Past the DUT update, before the RAM drives
      cycles++;
      trackRequests();
      compareEvents();
    end
    if (stallFetches < stallRepeats) begin
      $display("%0d ns: timeout after %0d cycles, %0d of %0d debug values, %0d of %0d stores",
               $time, cycles, dbgSeen, dbgCount, storeSeen, storeCount);
      failures++;
    end
    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches + failures == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/ramModel.sv
`timescale 1ns/1ps
`default_nettype none

module ramModel #(
  parameter int depth = 256  // Words
) (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] address,
  input  logic [31:0] writeData,
  input  logic        readReq,
  input  logic        writeReq,
  output logic [31:0] readData,
  output logic        readAck,
  output logic        writeAck,
  output logic        storeValid,    // Pulses with each write acknowledge
  output logic [31:0] storeAddress,
  output logic [31:0] storeWord
);

  localparam int idxBits = $clog2(depth);

  logic [31:0] mem [depth];
  integer seed;
  int delay;
  logic busy, isWrite;
  logic [31:0] reqAddress, reqData;

  initial begin
    seed = 69;
    delay = 0;
    busy = 1'b0;
    isWrite = 1'b0;
    readAck = 1'b0;
    writeAck = 1'b0;
    storeValid = 1'b0;
    readData = '0;
    storeAddress = '0;
    storeWord = '0;
    for (int i = 0; i < depth; i++) begin
      mem[i] = 32'hbad00000 | 32'(i);  // Unwritten words show their own index
    end
  end

  task automatic loadWord(input int index, input logic [31:0] word);
    mem[index] = word;
  endtask

  // Everything toward the DUT changes on the falling edge
  always @(negedge clk) begin
    readAck <= 1'b0;
    writeAck <= 1'b0;
    storeValid <= 1'b0;
    if (reset) begin
      busy <= 1'b0;
    end else if (busy) begin
      if (delay > 1) begin
        delay <= delay - 1;
      end else begin
        busy <= 1'b0;
        if (isWrite) begin
          mem[reqAddress[2 +: idxBits]] = reqData;
          writeAck <= 1'b1;
          storeValid <= 1'b1;
          storeAddress <= reqAddress;
          storeWord <= reqData;
        end else begin
          readData <= mem[reqAddress[2 +: idxBits]];
          readAck <= 1'b1;
        end
      end
    end else if (readReq || writeReq) begin
      busy <= 1'b1;
      isWrite <= writeReq;
      reqAddress <= address;  // Held by the core until the acknowledge anyway
      reqData <= writeData;
      delay <= 1 + ($unsigned($random(seed)) % 3);  // 1 to 3 cycles
    end
  end

endmodule

`default_nettype wire

// File: src/cpuCore.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore import cpuPkg::*; #(
  parameter int dataWidth = wordWidth,
  parameter int numRegs = 64
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [dataWidth-1:0] ramIn,
  input  logic                 readAck,
  input  logic                 writeAck,
  output logic [dataWidth-1:0] ramAddress,
  output logic [dataWidth-1:0] ramOut,
  output logic                 readReq,
  output logic                 writeReq,
  output logic                 dbgValid,
  output logic [dataWidth-1:0] dbgValue
);

  logic [dataWidth-1:0] instrWord, constWord, loadData, pc, nextPc;
  logic [dataWidth-1:0] valA, valB, valC, sp, flags;
  logic [dataWidth-1:0] accessAddress, storeData, dbgSource;
  logic [dataWidth-1:0] wrData, spData;
  logic [regIndexWidth-1:0] regA, regB, regC, wrIndex;
  opcodeT opcode;
  logic twoWord, load, store;
  logic operandCycle, accessCycle, finishCycle;
  logic wrEn, spWrEn;

  sequencer #(.dataWidth(dataWidth)) uSeq (
    .clk, .reset,
    .ramIn, .readAck, .writeAck,
    .ramAddress, .ramOut, .readReq, .writeReq,
    .instrWord, .constWord,
    .opcode, .twoWord, .load, .store,
    .accessAddress, .storeData,
    .nextPc, .pc,
    .operandCycle, .accessCycle, .finishCycle,
    .loadData,
    .dbgValid, .dbgValue, .dbgSource
  );

  instrDecoder #(.dataWidth(dataWidth), .numRegs(numRegs)) uDec (
    .instrWord, .opcode, .regA, .regB, .regC, .twoWord, .load, .store
  );

  registerFile #(.dataWidth(dataWidth), .numRegs(numRegs)) uRegs (
    .clk, .reset,
    .regA, .regB, .regC, .operandCycle,
    .valA, .valB, .valC, .sp, .flags,
    .wrEn, .wrIndex, .wrData, .spWrEn, .spData
  );

  addressUnit #(.dataWidth(dataWidth)) uAddr (
    .clk, .reset, .opcode,
    .valA, .valB, .valC, .sp, .pc, .constWord,
    .accessCycle, .accessAddress, .storeData
  );

  execUnit #(.dataWidth(dataWidth)) uExec (
    .opcode, .regA,
    .valA, .valB, .valC, .sp, .flags, .pc, .constWord, .loadData,
    .twoWord, .finishCycle,
    .wrEn, .wrIndex, .wrData, .spWrEn, .spData, .nextPc,
    .dbgSource
  );

endmodule

`default_nettype wire

// File: src/sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module sequencer import cpuPkg::*; #(
  parameter int dataWidth = wordWidth
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [dataWidth-1:0] ramIn,
  input  logic                 readAck,
  input  logic                 writeAck,
  output logic [dataWidth-1:0] ramAddress,
  output logic [dataWidth-1:0] ramOut,
  output logic                 readReq,
  output logic                 writeReq,
  output logic [dataWidth-1:0] instrWord,     // Latched first word
  output logic [dataWidth-1:0] constWord,     // Latched second word
  input  opcodeT               opcode,
  input  logic                 twoWord,
  input  logic                 load,
  input  logic                 store,
  input  logic [dataWidth-1:0] accessAddress,
  input  logic [dataWidth-1:0] storeData,
  input  logic [dataWidth-1:0] nextPc,
  output logic [dataWidth-1:0] pc,
  output logic                 operandCycle,
  output logic                 accessCycle,
  output logic                 finishCycle,
  output logic [dataWidth-1:0] loadData,
  output logic                 dbgValid,
  output logic [dataWidth-1:0] dbgValue,
  input  logic [dataWidth-1:0] dbgSource
);

  typedef enum logic [2:0] {
    sFetchReq,
    sFetchWait,
    sOperand,
    sConstReq,
    sConstWait,
    sAccessReq,
    sAccessWait,
    sFinish
  } stateT;

  stateT state;
  logic [dataWidth-1:0] fetchAddress;  // Instruction or constant word address

  assign operandCycle = (state == sOperand);
  assign accessCycle = (state == sAccessReq);   // addressUnit captures here
  assign finishCycle = (state == sFinish);

  // Data accesses use the address unit's registered address
  assign ramAddress = (state == sAccessWait) ? accessAddress : fetchAddress;
  assign ramOut = storeData;

  // Debug word leaves in the finish cycle only
  assign dbgValid = finishCycle && (opcode == doutR);
  assign dbgValue = dbgSource;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= sFetchReq;
      pc <= '0;
      fetchAddress <= '0;
      readReq <= 1'b0;
      writeReq <= 1'b0;
    end else begin
      readReq <= 1'b0;   // Requests are one-cycle pulses
      writeReq <= 1'b0;
      case (state)
        sFetchReq: begin
          readReq <= 1'b1;
          fetchAddress <= pc;
          state <= sFetchWait;
        end
        sFetchWait: if (readAck) state <= sOperand;
        sOperand: begin
          // Register file samples operands this cycle
          if (twoWord) state <= sConstReq;
          else if (load || store) state <= sAccessReq;
          else state <= sFinish;
        end
        sConstReq: begin
          readReq <= 1'b1;
          fetchAddress <= pc + 4;   // Constant follows the opcode word
          state <= sConstWait;
        end
        sConstWait: if (readAck) state <= (load || store) ? sAccessReq : sFinish;
        sAccessReq: begin
          readReq <= load;
          writeReq <= store;
          state <= sAccessWait;
        end
        sAccessWait: begin
          // Held here for as long as the RAM takes
          if ((load && readAck) || (store && writeAck)) state <= sFinish;
        end
        sFinish: begin
          pc <= nextPc;
          state <= sFetchReq;
        end
        default: state <= sFetchReq;
      endcase
    end
  end

  // Words captured on their acknowledge
  always_ff @(posedge clk) begin
    if (state == sFetchWait && readAck) instrWord <= ramIn;
    if (state == sConstWait && readAck) constWord <= ramIn;
    if (state == sAccessWait && readAck) loadData <= ramIn;
  end

endmodule

`default_nettype wire

// File: src/execUnit.sv
`timescale 1ns/1ps
`default_nettype none

module execUnit import cpuPkg::*; #(
  parameter int dataWidth = wordWidth
) (
  input  opcodeT                   opcode,
  input  logic [regIndexWidth-1:0] regA,
  input  logic [dataWidth-1:0]     valA,
  input  logic [dataWidth-1:0]     valB,
  input  logic [dataWidth-1:0]     valC,
  input  logic [dataWidth-1:0]     sp,
  input  logic [dataWidth-1:0]     flags,
  input  logic [dataWidth-1:0]     pc,
  input  logic [dataWidth-1:0]     constWord,
  input  logic [dataWidth-1:0]     loadData,
  input  logic                     twoWord,
  input  logic                     finishCycle,
  output logic                     wrEn,
  output logic [regIndexWidth-1:0] wrIndex,
  output logic [dataWidth-1:0]     wrData,
  output logic                     spWrEn,
  output logic [dataWidth-1:0]     spData,
  output logic [dataWidth-1:0]     nextPc,
  output logic [dataWidth-1:0]     dbgSource
);

  logic wrReq, spReq, jumpTaken;
  logic [dataWidth-1:0] seqPc;

  // Unsigned compare packed into flag word
  function automatic logic [dataWidth-1:0] cmpFlags(logic [dataWidth-1:0] a,
                                                     logic [dataWidth-1:0] b);
    logic [dataWidth-1:0] f;
    f = '0;
    f[flagEq] = (a == b);
    f[flagLt] = (a < b);
    f[flagGt] = (a > b);
    return f;
  endfunction

  always_comb begin
    wrReq = 1'b0;
    wrIndex = regA;     // Most results land in A
    wrData = '0;
    spReq = 1'b0;
    spData = sp;
    jumpTaken = 1'b0;
    case (opcode)
      movRC:     begin wrReq = 1'b1; wrData = constWord; end
      movRR:     begin wrReq = 1'b1; wrData = valB; end
      movRdC, movRdR, movRdRo, movRdRoR: begin
        wrReq = 1'b1;
        wrData = loadData;
      end
      pushR, callR: begin
        spReq = 1'b1;
        spData = sp + stackStep;  // Stack grows upward
      end
      popR: begin
        wrReq = 1'b1;
        wrData = loadData;
        spReq = 1'b1;
        spData = sp - stackStep;
      end
      ret:       begin spReq = 1'b1; spData = sp - stackStep; end
      cmpRR, cmpRC: begin
        wrReq = 1'b1;
        wrIndex = flagIndex;
        wrData = cmpFlags(valA, (opcode == cmpRC) ? constWord : valB);
      end
      cmpERRR:   begin wrReq = 1'b1; wrData = dataWidth'(valB == valC); end
      cmpNeRRR:  begin wrReq = 1'b1; wrData = dataWidth'(valB != valC); end
      cmpLtRRR:  begin wrReq = 1'b1; wrData = dataWidth'(valB < valC); end
      cmpGtRRR:  begin wrReq = 1'b1; wrData = dataWidth'(valB > valC); end
      jmpC:      jumpTaken = 1'b1;
      jeC:       jumpTaken = flags[flagEq];
      jneC:      jumpTaken = !flags[flagEq];
      jltC:      jumpTaken = flags[flagLt];
      jgtC:      jumpTaken = flags[flagGt];
      jzRC:      jumpTaken = (valC == '0);  // Zero test on C
      jnzRC:     jumpTaken = (valC != '0);
      addRRC:    begin wrReq = 1'b1; wrData = valB + constWord; end
      addRRR:    begin wrReq = 1'b1; wrData = valB + valC; end
      subRRC:    begin wrReq = 1'b1; wrData = valB - constWord; end
      subRRR:    begin wrReq = 1'b1; wrData = valB - valC; end
      incR:      begin wrReq = 1'b1; wrData = valA + 1'b1; end
      decR:      begin wrReq = 1'b1; wrData = valA - 1'b1; end
      shlRRR:    begin wrReq = 1'b1; wrData = valB << valC; end
      shrRRR:    begin wrReq = 1'b1; wrData = valB >> valC; end
      mulAddRRC: begin wrReq = 1'b1; wrData = valA + valB * constWord; end
      default:   ;  // Stores, dout, stall and unknown codes write nothing
    endcase
  end

  // Commit only in the finish cycle
  assign wrEn = finishCycle && wrReq;
  assign spWrEn = finishCycle && spReq;

  assign seqPc = twoWord ? pc + 8 : pc + 4;

  always_comb begin
    nextPc = seqPc;
    if (redirectsPc(opcode)) begin
      case (opcode)
        callR:   nextPc = valA;
        ret:     nextPc = loadData + 4;  // Resume after the call
        stall:   nextPc = pc;
        default: nextPc = jumpTaken ? constWord : seqPc;
      endcase
    end
  end

  assign dbgSource = valA;  // dout reads A

endmodule

`default_nettype wire

// File: src/addressUnit.sv
`timescale 1ns/1ps
`default_nettype none

module addressUnit import cpuPkg::*; #(
  parameter int dataWidth = wordWidth
) (
  input  logic                 clk,
  input  logic                 reset,
  input  opcodeT               opcode,
  input  logic [dataWidth-1:0] valA,
  input  logic [dataWidth-1:0] valB,
  input  logic [dataWidth-1:0] valC,
  input  logic [dataWidth-1:0] sp,
  input  logic [dataWidth-1:0] pc,
  input  logic [dataWidth-1:0] constWord,
  input  logic                 accessCycle,
  output logic [dataWidth-1:0] accessAddress,
  output logic [dataWidth-1:0] storeData
);

  logic [dataWidth-1:0] addrNext, dataNext;

  always_comb begin
    addrNext = constWord;   // Direct form
    dataNext = valB;
    case (opcode)
      movRdR:   addrNext = valB;
      movdRR:   addrNext = valA;
      movRdRo:  addrNext = constWord + valB;
      movdRoR:  addrNext = constWord + valA;
      movRdRoR: addrNext = valB + constWord * valC;   // Base + size * index
      movdRoRR: begin
        addrNext = valA + constWord * valB;
        dataNext = valC;
      end
      pushR:    begin addrNext = sp; dataNext = valA; end
      callR:    begin addrNext = sp; dataNext = pc; end  // Return address
      popR, ret: addrNext = sp - stackStep;
      default:  ;
    endcase
  end

  // Held stable through the access wait
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      accessAddress <= '0;
      storeData <= '0;
    end else if (accessCycle) begin
      accessAddress <= addrNext;
      storeData <= dataNext;
    end
  end

endmodule

`default_nettype wire

// File: src/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile import cpuPkg::*; #(
  parameter int dataWidth = wordWidth,
  parameter int numRegs = 64
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [regIndexWidth-1:0] regA,
  input  logic [regIndexWidth-1:0] regB,
  input  logic [regIndexWidth-1:0] regC,
  input  logic                     operandCycle,
  output logic [dataWidth-1:0]     valA,
  output logic [dataWidth-1:0]     valB,
  output logic [dataWidth-1:0]     valC,
  output logic [dataWidth-1:0]     sp,
  output logic [dataWidth-1:0]     flags,
  input  logic                     wrEn,
  input  logic [regIndexWidth-1:0] wrIndex,
  input  logic [dataWidth-1:0]     wrData,
  input  logic                     spWrEn,
  input  logic [dataWidth-1:0]     spData
);

  logic [dataWidth-1:0] regs [numRegs];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wrEn) regs[wrIndex] <= wrData;
      if (spWrEn) regs[spIndex] <= spData;  // Pop writes both, r0 last
    end
  end

  // Operand snapshot for the rest of the instruction
  always_ff @(posedge clk) begin
    if (operandCycle) begin
      valA <= regs[regA];
      valB <= regs[regB];
      valC <= regs[regC];
      sp <= regs[spIndex];
      flags <= regs[flagIndex];
    end
  end

endmodule

`default_nettype wire

// File: src/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder import cpuPkg::*; #(
  parameter int dataWidth = wordWidth,
  parameter int numRegs = 64
) (
  input  logic [dataWidth-1:0]     instrWord,
  output opcodeT                   opcode,
  output logic [regIndexWidth-1:0] regA,
  output logic [regIndexWidth-1:0] regB,
  output logic [regIndexWidth-1:0] regC,
  output logic                     twoWord,
  output logic                     load,
  output logic                     store
);

  // Only the low index bits of each register byte count
  localparam int idxBits = $clog2(numRegs);

  logic [idxBits-1:0] fieldA, fieldB, fieldC;

  assign opcode = opcodeT'(instrWord[opcodeLsb +: 8]);  // Unknown codes fall to default arms

  assign fieldA = instrWord[regALsb +: idxBits];
  assign fieldB = instrWord[regBLsb +: idxBits];
  assign fieldC = instrWord[regCLsb +: idxBits];

  // Zero-extend to the index width
  assign regA = regIndexWidth'(fieldA);
  assign regB = regIndexWidth'(fieldB);
  assign regC = regIndexWidth'(fieldC);

  // Classification kept next to the decode
  assign twoWord = isTwoWord(opcode);
  assign load = isLoad(opcode);
  assign store = isStore(opcode);

endmodule

`default_nettype wire

// File: src/cpuPkg.sv
`default_nettype none

package cpuPkg;

  localparam int wordWidth = 32;     // Data and address width
  localparam int regIndexWidth = 6;  // Enough for 64 registers

  // Byte lanes of the first instruction word
  localparam int opcodeLsb = 0;
  localparam int regALsb = 8;
  localparam int regBLsb = 16;
  localparam int regCLsb = 24;

  localparam logic [regIndexWidth-1:0] spIndex = 6'd0;    // Stack pointer
  localparam logic [regIndexWidth-1:0] flagIndex = 6'd1;  // Compare flags

  // Flag bits in r1
  localparam int flagEq = 0;
  localparam int flagLt = 1;
  localparam int flagGt = 2;

  localparam int stackStep = 4;  // Bytes per push or pop

  // A = byte 1, B = byte 2, C = byte 3; C is the constant word
  typedef enum logic [7:0] {
    movRC     = 8'h01, movRR     = 8'h02,
    movRdC    = 8'h03, movRdR    = 8'h04, movRdRo  = 8'h05, movRdRoR = 8'h06,
    movdCR    = 8'h07, movdRR    = 8'h08, movdRoR  = 8'h09, movdRoRR = 8'h0a,
    pushR     = 8'h10, popR      = 8'h11, callR    = 8'h12, ret      = 8'h13,
    cmpRR     = 8'h20, cmpRC     = 8'h21,
    cmpERRR   = 8'h22, cmpNeRRR  = 8'h23, cmpLtRRR = 8'h24, cmpGtRRR = 8'h25,
    jmpC      = 8'h30, jeC       = 8'h31, jneC     = 8'h32,
    jltC      = 8'h33, jgtC      = 8'h34, jzRC     = 8'h35, jnzRC    = 8'h36,
    addRRC    = 8'h40, addRRR    = 8'h41, subRRC   = 8'h42, subRRR   = 8'h43,
    incR      = 8'h44, decR      = 8'h45, shlRRR   = 8'h46, shrRRR   = 8'h47,
    mulAddRRC = 8'h48,
    doutR     = 8'h50, stall     = 8'h51
  } opcodeT;

  // Opcodes followed by a constant word
  function automatic logic isTwoWord(opcodeT op);
    return op inside {movRC, movRdC, movRdRo, movRdRoR, movdCR, movdRoR, movdRoRR,
                      cmpRC, jmpC, jeC, jneC, jltC, jgtC, jzRC, jnzRC,
                      addRRC, subRRC, mulAddRRC};
  endfunction

  function automatic logic isLoad(opcodeT op);
    return op inside {movRdC, movRdR, movRdRo, movRdRoR, popR, ret};
  endfunction

  function automatic logic isStore(opcodeT op);
    return op inside {movdCR, movdRR, movdRoR, movdRoRR, pushR, callR};
  endfunction

  // Anything that may leave the sequential pc path
  function automatic logic redirectsPc(opcodeT op);
    return op inside {jmpC, jeC, jneC, jltC, jgtC, jzRC, jnzRC, callR, ret, stall};
  endfunction

endpackage

`default_nettype wire
